// ==== include/pov_defs.svh ====
`ifndef POV_DEFS_SVH
`define POV_DEFS_SVH

// SPI command frame: opcode byte plus 48-bit payload
`define POV_CMD_BITS 56

// Status word shifted back to the host
`define POV_RESP_BITS 48

// Driver configuration register width
`define POV_CONF_BITS 48

// Columns in one revolution
`define POV_COLUMNS 32

// Idle clocks between two columns
`define POV_BLANKING 72

`endif

// ==== hw/pov_pkg.sv ====
`default_nettype none

package pov_pkg;

    // Host commands, anything else is dropped
    typedef enum logic [7:0] {
        OP_NOP          = 8'h00,
        OP_SET_ROTATION = 8'h01,
        OP_WRITE_CONF   = 8'h02,
        OP_RGB_ENABLE   = 8'h03
    } opcode_e;

    typedef struct packed {
        opcode_e     op;
        logic [47:0] payload;
    } cmd_frame_t;

    typedef struct packed {
        opcode_e     last_op;
        logic [15:0] rotation;
        logic [7:0]  conf_count;
        logic [14:0] reserved;
        logic        rgb_enable;
    } status_t;

    typedef struct packed {
        logic [9:0] red;
        logic [9:0] green;
        logic [9:0] blue;
    } col_word_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_APPLY,
        ST_REPORT
    } dec_state_e;

    typedef enum logic [1:0] {
        SH_IDLE,
        SH_SHIFT,
        SH_LATCH
    } sh_state_e;

endpackage

`default_nettype wire

// ==== hw/pov_cfg_if.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pov_defs.svh"

// Display settings from the decoder to the datapath blocks
interface pov_cfg_if;
    logic [15:0]               rotation;
    logic                      rgb_enable;
    logic [`POV_CONF_BITS-1:0] conf;
    // One-cycle strobe, conf is valid from the same cycle on
    logic                      conf_load;

    modport decoder (
        output rotation,
        output rgb_enable,
        output conf,
        output conf_load
    );

    modport generator (
        input rotation,
        input rgb_enable
    );

    modport shifter (
        input conf,
        input conf_load
    );
endinterface

`default_nettype wire

// ==== hw/spi_frame_rx.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pov_defs.svh"

module spi_frame_rx (
    input  logic                clock_33,
    input  logic                nrst,
    input  logic                spi_clk,
    input  logic                spi_ss,
    input  logic                spi_mosi,
    output logic                spi_miso,
    output pov_pkg::cmd_frame_t frame,
    output logic                frame_valid,
    input  pov_pkg::status_t    status
);

    localparam int CNT_W = $clog2(`POV_CMD_BITS + 1);

    // Stages 0 and 1 synchronize, stage 2 keeps the previous value
    logic [2:0]                clk_sync;
    logic [2:0]                ss_sync;
    logic [1:0]                mosi_sync;
    logic                      sclk_rise;
    logic                      sclk_fall;
    logic                      ss_rise;
    logic                      ss_fall;
    logic                      ss_active;
    logic [1:0]                ss_rise_d;
    logic [CNT_W-1:0]          bit_cnt;
    logic [`POV_CMD_BITS-1:0]  rx_shift;
    logic [`POV_RESP_BITS-1:0] tx_shift;
    logic                      frame_ok;

    assign sclk_rise = clk_sync[1] && !clk_sync[2];
    assign sclk_fall = !clk_sync[1] && clk_sync[2];
    assign ss_rise   = ss_sync[1] && !ss_sync[2];
    assign ss_fall   = !ss_sync[1] && ss_sync[2];
    assign ss_active = !ss_sync[1];
    assign frame_ok  = ss_rise_d[1] && (bit_cnt == CNT_W'(`POV_CMD_BITS));
    assign spi_miso  = tx_shift[`POV_RESP_BITS-1];

    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            clk_sync  <= '0;
            // Select idles high, so no false edge out of reset
            ss_sync   <= '1;
            mosi_sync <= '0;
        end else begin
            clk_sync  <= {clk_sync[1:0], spi_clk};
            ss_sync   <= {ss_sync[1:0], spi_ss};
            mosi_sync <= {mosi_sync[0], spi_mosi};
        end
    end

    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            bit_cnt     <= '0;
            ss_rise_d   <= '0;
            frame_valid <= 1'b0;
            tx_shift    <= '0;
        end else begin
            ss_rise_d   <= {ss_rise_d[0], ss_rise};
            frame_valid <= frame_ok;

            // Saturate so an overlong frame never wraps back to a valid count
            if (ss_fall) begin
                bit_cnt <= '0;
            end else if (ss_active && sclk_rise && bit_cnt != '1) begin
                bit_cnt <= bit_cnt + 1'b1;
            end

            // Status snapshot at select, then MSB first on each falling clock
            if (ss_fall) begin
                tx_shift <= status;
            end else if (ss_active && sclk_fall) begin
                tx_shift <= {tx_shift[`POV_RESP_BITS-2:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clock_33) begin
        if (ss_active && sclk_rise) begin
            rx_shift <= {rx_shift[`POV_CMD_BITS-2:0], mosi_sync[1]};
        end
        if (frame_ok) begin
            frame <= pov_pkg::cmd_frame_t'(rx_shift);
        end
    end

    a_valid_single: assert property (@(posedge clock_33) disable iff (!nrst)
        frame_valid |=> !frame_valid);

endmodule

`default_nettype wire

// ==== hw/pov_cmd_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pov_defs.svh"

module pov_cmd_decoder (
    input  logic                clock_33,
    input  logic                nrst,
    input  pov_pkg::cmd_frame_t frame,
    input  logic                frame_valid,
    output pov_pkg::status_t    status,
    pov_cfg_if.decoder          cfg,
    output logic                new_config
);

    pov_pkg::dec_state_e       state;
    pov_pkg::opcode_e          last_op;
    logic [15:0]               rotation;
    logic [7:0]                conf_count;
    logic                      rgb_enable;
    logic [`POV_CONF_BITS-1:0] conf;
    logic                      op_known;
    logic                      take;
    logic                      conf_strobe;

    always_comb begin
        case (frame.op)
            pov_pkg::OP_NOP,
            pov_pkg::OP_SET_ROTATION,
            pov_pkg::OP_WRITE_CONF,
            pov_pkg::OP_RGB_ENABLE: op_known = 1'b1;
            default:                op_known = 1'b0;
        endcase
    end

    // Frames arriving outside idle are dropped
    assign take = frame_valid && op_known && (state == pov_pkg::ST_IDLE);

    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            state      <= pov_pkg::ST_IDLE;
            last_op    <= pov_pkg::OP_NOP;
            rotation   <= '0;
            conf_count <= '0;
            rgb_enable <= 1'b0;
        end else begin
            case (state)
                pov_pkg::ST_IDLE: begin
                    if (take) begin
                        last_op <= frame.op;
                        case (frame.op)
                            pov_pkg::OP_SET_ROTATION: rotation <= frame.payload[15:0];
                            pov_pkg::OP_WRITE_CONF:   conf_count <= conf_count + 8'd1;
                            pov_pkg::OP_RGB_ENABLE:   rgb_enable <= frame.payload[0];
                            default: ;
                        endcase
                        state <= pov_pkg::ST_APPLY;
                    end
                end
                // Settings are out, downstream sees the config strobe here
                pov_pkg::ST_APPLY:  state <= pov_pkg::ST_REPORT;
                // Hold-off cycle before the next frame is accepted
                pov_pkg::ST_REPORT: state <= pov_pkg::ST_IDLE;
                default:            state <= pov_pkg::ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock_33) begin
        if (take && frame.op == pov_pkg::OP_WRITE_CONF) begin
            conf <= frame.payload;
        end
    end

    assign conf_strobe = (state == pov_pkg::ST_APPLY) && (last_op == pov_pkg::OP_WRITE_CONF);

    assign cfg.rotation   = rotation;
    assign cfg.rgb_enable = rgb_enable;
    assign cfg.conf       = conf;
    assign cfg.conf_load  = conf_strobe;
    assign new_config     = conf_strobe;

    always_comb begin
        status            = '0;
        status.last_op    = last_op;
        status.rotation   = rotation;
        status.conf_count = conf_count;
        status.rgb_enable = rgb_enable;
    end

    a_conf_source: assert property (@(posedge clock_33) disable iff (!nrst)
        cfg.conf_load |-> $past(frame_valid && frame.op == pov_pkg::OP_WRITE_CONF));

endmodule

`default_nettype wire

// ==== hw/column_pattern_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pov_defs.svh"

module column_pattern_gen (
    input  logic               clock_33,
    input  logic               nrst,
    pov_cfg_if.generator       cfg,
    output pov_pkg::col_word_t col_data,
    output logic               col_valid,
    input  logic               col_ready
);

    localparam int IDX_W = $clog2(`POV_COLUMNS);
    localparam int BLK_W = $clog2(`POV_BLANKING);

    logic [IDX_W-1:0] col_idx;
    logic [BLK_W-1:0] blank_cnt;
    logic             stalled;
    logic             blank_done;
    logic             launch;

    assign stalled    = col_valid && !col_ready;
    assign blank_done = (blank_cnt == BLK_W'(`POV_BLANKING - 1));
    assign launch     = !col_valid && cfg.rgb_enable && blank_done;

    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            col_idx   <= '0;
            blank_cnt <= '0;
            col_valid <= 1'b0;
        end else if (!stalled) begin
            if (col_valid) begin
                // Accepted, restart the blanking gap
                col_valid <= 1'b0;
                blank_cnt <= '0;
                if (col_idx == IDX_W'(`POV_COLUMNS - 1)) begin
                    col_idx <= '0;
                end else begin
                    col_idx <= col_idx + 1'b1;
                end
            end else if (!cfg.rgb_enable) begin
                col_idx   <= '0;
                blank_cnt <= '0;
            end else if (launch) begin
                col_valid <= 1'b1;
            end else begin
                blank_cnt <= blank_cnt + 1'b1;
            end
        end
    end

    // Captured once per column so rotation updates cannot disturb an offer
    always_ff @(posedge clock_33) begin
        if (launch) begin
            col_data.red   <= 10'(col_idx);
            col_data.green <= cfg.rotation[9:0];
            col_data.blue  <= ~10'(col_idx);
        end
    end

    a_hold: assert property (@(posedge clock_33) disable iff (!nrst)
        stalled |=> col_valid && $stable(col_data));

endmodule

`default_nettype wire

// ==== hw/led_driver_shifter.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pov_defs.svh"

module led_driver_shifter (
    input  logic               clock_33,
    input  logic               nrst,
    pov_cfg_if.shifter         cfg,
    input  pov_pkg::col_word_t col_data,
    input  logic               col_valid,
    output logic               col_ready,
    output logic               driver_sclk,
    output logic               driver_lat,
    output logic               driver_sin
);

    // Mode bit plus payload
    localparam int SH_W  = `POV_CONF_BITS + 1;
    localparam int COL_W = $bits(pov_pkg::col_word_t) + 1;
    localparam int CNT_W = $clog2(SH_W + 1);

    pov_pkg::sh_state_e state;
    logic [SH_W-1:0]    shreg;
    logic [CNT_W-1:0]   bits_left;
    logic               conf_pending;
    logic               start_conf;
    logic               start_col;

    // Config requests take priority over columns
    assign col_ready  = (state == pov_pkg::SH_IDLE) && !conf_pending;
    assign start_conf = (state == pov_pkg::SH_IDLE) && conf_pending;
    assign start_col  = col_ready && col_valid;
    assign driver_sin = shreg[SH_W-1];

    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            state        <= pov_pkg::SH_IDLE;
            shreg        <= '0;
            bits_left    <= '0;
            conf_pending <= 1'b0;
            driver_sclk  <= 1'b0;
            driver_lat   <= 1'b0;
        end else begin
            driver_lat <= 1'b0;
            if (cfg.conf_load) begin
                conf_pending <= 1'b1;
            end

            case (state)
                pov_pkg::SH_IDLE: begin
                    if (start_conf) begin
                        // The loaded word is the latest conf, so a
                        // strobe in this cycle is already covered
                        shreg        <= {1'b1, cfg.conf};
                        bits_left    <= CNT_W'(SH_W);
                        conf_pending <= 1'b0;
                        state        <= pov_pkg::SH_SHIFT;
                    end else if (start_col) begin
                        shreg     <= {1'b0, col_data, {(SH_W - COL_W){1'b0}}};
                        bits_left <= CNT_W'(COL_W);
                        state     <= pov_pkg::SH_SHIFT;
                    end
                end
                pov_pkg::SH_SHIFT: begin
                    driver_sclk <= !driver_sclk;
                    if (driver_sclk) begin
                        // Falling edge, present the next bit
                        shreg     <= {shreg[SH_W-2:0], 1'b0};
                        bits_left <= bits_left - 1'b1;
                        if (bits_left == CNT_W'(1)) begin
                            state <= pov_pkg::SH_LATCH;
                        end
                    end
                end
                pov_pkg::SH_LATCH: begin
                    driver_lat <= 1'b1;
                    state      <= pov_pkg::SH_IDLE;
                end
                default: state <= pov_pkg::SH_IDLE;
            endcase
        end
    end

    a_lat_sclk_low: assert property (@(posedge clock_33) disable iff (!nrst)
        $rose(driver_lat) |-> !driver_sclk);

endmodule

`default_nettype wire

// ==== hw/pov_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module pov_top (
    input  logic clock_33,
    input  logic nrst,
    input  logic spi_clk,
    input  logic spi_ss,
    input  logic spi_mosi,
    output logic spi_miso,
    output logic driver_sclk,
    output logic driver_lat,
    output logic driver_sin,
    output logic rgb_enable,
    output logic new_config
);

    pov_cfg_if cfg_bus ();

    pov_pkg::cmd_frame_t frame;
    logic                frame_valid;
    pov_pkg::status_t    status;
    pov_pkg::col_word_t  col_data;
    logic                col_valid;
    logic                col_ready;

    spi_frame_rx u_spi_rx (
        .clock_33    (clock_33),
        .nrst        (nrst),
        .spi_clk     (spi_clk),
        .spi_ss      (spi_ss),
        .spi_mosi    (spi_mosi),
        .spi_miso    (spi_miso),
        .frame       (frame),
        .frame_valid (frame_valid),
        .status      (status)
    );

    pov_cmd_decoder u_decoder (
        .clock_33    (clock_33),
        .nrst        (nrst),
        .frame       (frame),
        .frame_valid (frame_valid),
        .status      (status),
        .cfg         (cfg_bus.decoder),
        .new_config  (new_config)
    );

    column_pattern_gen u_pattern (
        .clock_33  (clock_33),
        .nrst      (nrst),
        .cfg       (cfg_bus.generator),
        .col_data  (col_data),
        .col_valid (col_valid),
        .col_ready (col_ready)
    );

    led_driver_shifter u_shifter (
        .clock_33    (clock_33),
        .nrst        (nrst),
        .cfg         (cfg_bus.shifter),
        .col_data    (col_data),
        .col_valid   (col_valid),
        .col_ready   (col_ready),
        .driver_sclk (driver_sclk),
        .driver_lat  (driver_lat),
        .driver_sin  (driver_sin)
    );

    assign rgb_enable = cfg_bus.rgb_enable;

endmodule

`default_nettype wire

// ==== tb/pov_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pov_defs.svh"

module pov_tb;

    localparam int NUM_ROWS       = 9;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 600 + 5000;

    typedef struct packed {
        pov_pkg::cmd_frame_t frame;
        logic [7:0]          nbits;
        logic [7:0]          wait_cols;
        pov_pkg::status_t    exp_status;
        logic                has_word;
        logic [47:0]         exp_word;
    } row_t;

    logic clock_33;
    logic nrst;
    logic spi_clk;
    logic spi_ss;
    logic spi_mosi;
    wire  spi_miso;
    wire  driver_sclk;
    wire  driver_lat;
    wire  driver_sin;
    wire  rgb_enable;
    wire  new_config;

    integer           seed;
    row_t             rows [NUM_ROWS];
    int               row_count = 0;
    pov_pkg::status_t model = '0;
    int               cycle_count = 0;

    // Serial line monitor state
    logic             sclk_d = 1'b0;
    logic [48:0]      shift_word = '0;
    int               shift_len = 0;
    int               cfg_pulses = 0;
    logic [48:0]      word_q [$];
    int               len_q [$];
    int               tag_q [$];

    // Word checker state
    logic [47:0]      exp_confs [$];
    int               exp_idx = 0;
    int               cols_seen = 0;
    int               confs_done = 0;
    int               late_cols = 0;

    pov_top DUT (
        .clock_33    (clock_33),
        .nrst        (nrst),
        .spi_clk     (spi_clk),
        .spi_ss      (spi_ss),
        .spi_mosi    (spi_mosi),
        .spi_miso    (spi_miso),
        .driver_sclk (driver_sclk),
        .driver_lat  (driver_lat),
        .driver_sin  (driver_sin),
        .rgb_enable  (rgb_enable),
        .new_config  (new_config)
    );

    initial begin
        clock_33 = 1'b0;
        forever #50 clock_33 = ~clock_33;
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    always @(posedge clock_33) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_with_error("Simulation timed out before all commands were checked");
        end
    end

    // Collect driver_sin on each sclk rise, hand the word over at the latch
    always @(posedge clock_33) begin
        if (driver_sclk && !sclk_d) begin
            shift_word = {shift_word[47:0], driver_sin};
            shift_len++;
        end
        if (driver_lat) begin
            word_q.push_back(shift_word);
            len_q.push_back(shift_len);
            tag_q.push_back(cfg_pulses);
            shift_word = '0;
            shift_len  = 0;
        end
        if (new_config) begin
            cfg_pulses++;
        end
        sclk_d = driver_sclk;
    end

    task automatic check_status(input string name, input pov_pkg::status_t got,
                                input pov_pkg::status_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED t=%0t %s got=%h expected=%h", $time, name, got, exp);
            stop_with_error("Status word mismatch");
        end
    endtask

    task automatic check_col(input string name, input pov_pkg::col_word_t got,
                             input pov_pkg::col_word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED t=%0t %s got=%h expected=%h", $time, name, got, exp);
            stop_with_error("Column word mismatch");
        end
    endtask

    task automatic check_conf(input string name, input logic [`POV_CONF_BITS-1:0] got,
                              input logic [`POV_CONF_BITS-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED t=%0t %s got=%h expected=%h", $time, name, got, exp);
            stop_with_error("Configuration word mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED t=%0t %s got=%b expected=%b", $time, name, got, exp);
            stop_with_error("Single bit mismatch");
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("CHECK FAILED t=%0t %s got=%0d expected=%0d", $time, name, got, exp);
            stop_with_error("Count mismatch");
        end
    endtask

    // Inputs move 10 ns after the rising edge
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clock_33);
        #10;
    endtask

    function automatic logic [47:0] random_payload();
        logic [63:0] r;
        r = {$random(seed), $random(seed)};
        return r[47:0];
    endfunction

    // Expected effect of one frame on the status word
    function automatic pov_pkg::status_t apply_rules(input pov_pkg::status_t s,
                                                     input pov_pkg::cmd_frame_t f,
                                                     input int nbits);
        pov_pkg::status_t n;
        n = s;
        if (nbits != `POV_CMD_BITS) begin
            return s;
        end
        case (f.op)
            pov_pkg::OP_NOP:          n.last_op = f.op;
            pov_pkg::OP_SET_ROTATION: begin
                n.last_op  = f.op;
                n.rotation = f.payload[15:0];
            end
            pov_pkg::OP_WRITE_CONF: begin
                n.last_op    = f.op;
                n.conf_count = s.conf_count + 8'd1;
            end
            pov_pkg::OP_RGB_ENABLE: begin
                n.last_op    = f.op;
                n.rgb_enable = f.payload[0];
            end
            default: n = s;
        endcase
        return n;
    endfunction

    task automatic add_row(input pov_pkg::opcode_e op, input logic [47:0] payload,
                           input int nbits, input int wait_cols);
        pov_pkg::status_t prev;
        prev = (row_count == 0) ? pov_pkg::status_t'('0) : rows[row_count-1].exp_status;
        rows[row_count].frame.op      = op;
        rows[row_count].frame.payload = payload;
        rows[row_count].nbits         = 8'(nbits);
        rows[row_count].wait_cols     = 8'(wait_cols);
        rows[row_count].exp_status    = apply_rules(prev, rows[row_count].frame, nbits);
        rows[row_count].has_word      = (op == pov_pkg::OP_WRITE_CONF) &&
                                        (nbits == `POV_CMD_BITS);
        rows[row_count].exp_word      = payload;
        row_count++;
    endtask

    task automatic fill_table();
        add_row(pov_pkg::OP_SET_ROTATION, random_payload(), 56, 0);
        add_row(pov_pkg::OP_WRITE_CONF, random_payload(), 56, 0);
        // Short frame, must be dropped
        add_row(pov_pkg::OP_WRITE_CONF, random_payload(), 40, 0);
        add_row(pov_pkg::opcode_e'(8'h5a), random_payload(), 56, 0);
        // Stream past the wrap at 32 columns
        add_row(pov_pkg::OP_RGB_ENABLE, random_payload() | 48'h1, 56, 34);
        add_row(pov_pkg::OP_WRITE_CONF, random_payload(), 56, 3);
        add_row(pov_pkg::OP_RGB_ENABLE, random_payload() & ~48'h1, 56, 0);
        add_row(pov_pkg::OP_SET_ROTATION, random_payload(), 56, 0);
        add_row(pov_pkg::OP_NOP, random_payload(), 56, 0);
    endtask

    // SPI mode 0 master, 4 clocks per phase, returns the status shifted back
    task automatic send_frame(input pov_pkg::cmd_frame_t f, input int nbits,
                              output pov_pkg::status_t rd);
        logic [`POV_CMD_BITS-1:0]  bits;
        logic [`POV_RESP_BITS-1:0] got;
        int                        i;
        bits   = f;
        got    = '0;
        spi_ss = 1'b0;
        wait_cycles(4);
        for (i = 0; i < nbits; i++) begin
            spi_mosi = bits[`POV_CMD_BITS-1-i];
            wait_cycles(4);
            if (i < `POV_RESP_BITS) begin
                got[`POV_RESP_BITS-1-i] = spi_miso;
            end
            spi_clk = 1'b1;
            wait_cycles(4);
            spi_clk = 1'b0;
        end
        wait_cycles(4);
        spi_ss   = 1'b1;
        spi_mosi = 1'b0;
        wait_cycles(8);
        rd = got;
    endtask

    task automatic process_words();
        logic [48:0]        w;
        int                 len;
        int                 tag;
        logic               mode;
        pov_pkg::col_word_t exp_col;
        while (word_q.size() > 0) begin
            w   = word_q.pop_front();
            len = len_q.pop_front();
            tag = tag_q.pop_front();
            if (len != 31 && len != 49) begin
                stop_with_error("Driver word latched with a bit count that fits no format");
            end
            mode = w[len-1];
            check_count("driver word length", len, mode ? 49 : 31);
            if (mode) begin
                if (exp_confs.size() == 0) begin
                    stop_with_error("Driver latched a configuration word nobody requested");
                end
                check_conf("driver conf word", w[47:0], exp_confs.pop_front());
                confs_done++;
                late_cols = 0;
            end else begin
                exp_col.red   = 10'(exp_idx);
                exp_col.green = model.rotation[9:0];
                exp_col.blue  = ~10'(exp_idx);
                check_col("driver column word", pov_pkg::col_word_t'(w[29:0]), exp_col);
                exp_idx = (exp_idx + 1) % `POV_COLUMNS;
                cols_seen++;
                // Only the column already in flight may pass a pending config
                if (tag > confs_done) begin
                    late_cols++;
                    if (late_cols > 1) begin
                        stop_with_error("Configuration word was not latched before the next column");
                    end
                end
            end
        end
    endtask

    initial begin
        int                  r;
        int                  pulses_before;
        int                  target;
        pov_pkg::status_t    readback;
        pov_pkg::cmd_frame_t nop_frame;

        seed     = 32'hceec;
        nrst     = 1'b0;
        spi_clk  = 1'b0;
        spi_ss   = 1'b1;
        spi_mosi = 1'b0;
        fill_table();
        nop_frame.op      = pov_pkg::OP_NOP;
        nop_frame.payload = '0;

        repeat (16) @(posedge clock_33);
        #10;
        nrst = 1'b1;
        wait_cycles(2);
        check_bit("rgb_enable", rgb_enable, 1'b0);
        check_bit("new_config", new_config, 1'b0);

        for (r = 0; r < NUM_ROWS; r++) begin
            pulses_before = cfg_pulses;
            send_frame(rows[r].frame, rows[r].nbits, readback);
            // Status read back reflects all rows before this one
            if (rows[r].nbits == `POV_CMD_BITS) begin
                check_status("status readback", readback, model);
            end
            process_words();
            if (!model.rgb_enable && rows[r].exp_status.rgb_enable) begin
                exp_idx = 0;
            end
            model = rows[r].exp_status;
            if (rows[r].has_word) begin
                exp_confs.push_back(rows[r].exp_word);
            end
            target = cols_seen + rows[r].wait_cols;
            wait_cycles(12);
            check_bit("rgb_enable", rgb_enable, model.rgb_enable);
            while (exp_confs.size() != 0 || cols_seen < target) begin
                wait_cycles(1);
                process_words();
            end
            check_count("new_config pulses", cfg_pulses - pulses_before,
                        rows[r].has_word ? 1 : 0);
        end

        send_frame(nop_frame, `POV_CMD_BITS, readback);
        check_status("final status readback", readback, model);
        process_words();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+include
hw/pov_pkg.sv
hw/pov_cfg_if.sv
hw/spi_frame_rx.sv
hw/pov_cmd_decoder.sv
hw/column_pattern_gen.sv
hw/led_driver_shifter.sv
hw/pov_top.sv
tb/pov_tb.sv

// ==== Bender.yml ====
package:
  name: pov_display

sources:
  - include_dirs:
      - include
    files:
      - hw/pov_pkg.sv
      - hw/pov_cfg_if.sv
      - hw/spi_frame_rx.sv
      - hw/pov_cmd_decoder.sv
      - hw/column_pattern_gen.sv
      - hw/led_driver_shifter.sv
      - hw/pov_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/pov_tb.sv
